//--- compile.f
+incdir+include
verilog/dio_pkg.sv
verilog/spi_shift_in.sv
verilog/dio_cmd_decoder.sv
verilog/ram_port.sv
verilog/spi_shift_out.sv
verilog/data_io_top.sv
test/dio_checker.sv
test/tb_data_io.sv

//--- test/tb_data_io.sv
// data_io testbench
// plays a table of file transfer frames into the serial link, one frame
// per row, with a small ram model on the read side
// the comparing is done by dio_checker

`default_nettype none

`include "dio_defs.svh"

module tb_data_io;

	localparam int ROWS = 13;

	logic                       sck;
	logic                       ss;
	logic                       frame;
	logic                       sdi;
	logic                       sdo;
	logic                       wr;
	logic [`DIO_ADDR_WIDTH-1:0] a;
	logic [3:0]                 sel;
	logic [31:0]                dout;
	logic [7:0]                 din;
	logic [`DIO_ADDR_WIDTH-1:0] size;
	logic [7:0]                 index;
	logic                       downloading;
	logic                       uploading;
	// towards the checker
	logic [63:0]                cur_name;
	logic                       chk_req;
	logic                       exp_dl;
	logic                       exp_ul;
	logic                       chk_idle;
	int                         chk_errs;
	int                         tmo_errs;
	integer                     seed;
	// row holds name, six frame bytes, byte count and the dl and ul flags
	logic [116:0]               tbl [ROWS];
	logic [7:0]                 fbytes [6];

	// ram read data is an xor pattern over the whole address
	assign din = a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;

	initial sck = 1'b0;
	always #20 sck = ~sck;

	data_io_top dut0 (
		.sck(sck), .ss(ss), .frame_i(frame), .sdi_i(sdi), .sdo_o(sdo),
		.wr_o(wr), .a_o(a), .sel_o(sel), .dout_o(dout), .din_i(din),
		.size_o(size), .index_o(index), .downloading_o(downloading), .uploading_o(uploading)
	);

	dio_checker chk0 (
		.sck(sck), .ss(ss), .frame_i(frame), .sdi_i(sdi), .sdo_i(sdo),
		.wr_i(wr), .a_i(a), .sel_i(sel), .dout_i(dout), .size_i(size), .index_i(index),
		.downloading_i(downloading), .uploading_i(uploading), .name_i(cur_name),
		.check_i(chk_req), .exp_dl_i(exp_dl), .exp_ul_i(exp_ul),
		.errors_o(chk_errs), .idle_o(chk_idle)
	);

	// unpack one row and draw download payload bytes at random
	task automatic load_row(input logic [116:0] r);
		cur_name = r[116:53];
		for (int k = 0; k < 6; k++) begin
			fbytes[k] = r[52-8*k -: 8];
			if (k > 0 && r[52:45] == `DIO_CMD_FILE_TX_DAT)
				fbytes[k] = 8'($random(seed));
		end
	endtask

	// one frame msb first with every bit set up on the falling edge
	task automatic send_frame(input int n);
		for (int i = 0; i < n; i++) begin
			for (int b = 7; b >= 0; b--) begin
				@(negedge sck);
				frame <= 1'b1;
				sdi   <= fbytes[i][b];
			end
		end
		@(negedge sck);
		frame <= 1'b0;
		sdi   <= 1'b0;
	endtask

	// outputs of a fresh dut are quiet within a few cycles
	task automatic wait_reset(input int limit);
		int n;
		n = 0;
		while ((wr !== 1'b0 || downloading !== 1'b0 || uploading !== 1'b0) && n < limit) begin
			@(negedge sck);
			n++;
		end
		if (wr !== 1'b0 || downloading !== 1'b0 || uploading !== 1'b0) begin
			$display("timeout: dut outputs did not go quiet after reset");
			tmo_errs++;
		end
	endtask

	// frame is complete once the checker has seen all its ram writes
	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		@(posedge sck);
		while (!chk_idle && n < limit) begin
			@(posedge sck);
			n++;
		end
		if (!chk_idle) begin
			$display("timeout: ram writes of frame %0s never arrived", cur_name);
			tmo_errs++;
		end
	endtask

	// hand the expected flags to the checker for one compare
	task automatic request_check(input logic dl, input logic ul);
		@(negedge sck);
		exp_dl  <= dl;
		exp_ul  <= ul;
		chk_req <= 1'b1;
		@(negedge sck);
		chk_req <= 1'b0;
		@(negedge sck);
	endtask

	initial begin
		seed     = 32'h8e28_68b7;
		ss       = 1'b1;
		frame    = 1'b0;
		sdi      = 1'b0;
		chk_req  = 1'b0;
		exp_dl   = 1'b0;
		exp_ul   = 1'b0;
		tmo_errs = 0;
		cur_name = "rst_stat";
		//        name        frame bytes             count  dl ul
		tbl[0]  = {"dl_start", 48'h53_01_00_00_00_00, 3'd2, 2'b10};
		tbl[1]  = {"dl_dat_a", 48'h54_00_00_00_00_00, 3'd6, 2'b10};
		tbl[2]  = {"dl_dat_b", 48'h54_00_00_00_00_00, 3'd4, 2'b10};
		tbl[3]  = {"dl_stop1", 48'h53_00_00_00_00_00, 3'd2, 2'b00};
		tbl[4]  = {"menu_idx", 48'h55_a7_00_00_00_00, 3'd2, 2'b00};
		tbl[5]  = {"ul_start", 48'h57_01_00_00_00_00, 3'd2, 2'b01};
		tbl[6]  = {"ul_dat_a", 48'h58_00_00_00_00_00, 3'd5, 2'b01};
		tbl[7]  = {"ul_dat_b", 48'h58_00_00_00_00_00, 3'd3, 2'b01};
		tbl[8]  = {"ul_stop1", 48'h57_00_00_00_00_00, 3'd2, 2'b00};
		tbl[9]  = {"dl_reopn", 48'h53_ff_00_00_00_00, 3'd2, 2'b10};
		tbl[10] = {"dl_dat_c", 48'h54_00_00_00_00_00, 3'd3, 2'b10};
		tbl[11] = {"idx_busy", 48'h55_3c_00_00_00_00, 3'd2, 2'b10};
		tbl[12] = {"dl_stop2", 48'h53_00_00_00_00_00, 3'd2, 2'b00};

		// ********************
		// reset and then one frame per row
		// ********************
		repeat (5) @(posedge sck);
		@(negedge sck);
		ss <= 1'b0;
		wait_reset(20);
		request_check(1'b0, 1'b0);
		for (int row = 0; row < ROWS && tmo_errs == 0; row++) begin
			load_row(tbl[row]);
			send_frame(tbl[row][4:2]);
			wait_idle(40);
			// idle gap before the state compare
			repeat (3) @(negedge sck);
			request_check(tbl[row][1], tbl[row][0]);
		end
		repeat (4) @(negedge sck);

		$display("errors: %0d from checks, %0d timeouts", chk_errs, tmo_errs);
		if (chk_errs == 0 && tmo_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/dio_checker.sv
// data_io checker
// rebuilds each frame from the serial lines, runs a reference model of the
// file commands and compares ram writes, returned bytes and transfer state

`default_nettype none

`include "dio_defs.svh"

module dio_checker (
	input  wire                        sck,
	input  wire                        ss,
	input  wire                        frame_i,
	input  wire                        sdi_i,
	input  wire                        sdo_i,
	input  wire                        wr_i,
	input  wire  [`DIO_ADDR_WIDTH-1:0] a_i,
	input  wire  [3:0]                 sel_i,
	input  wire  [31:0]                dout_i,
	input  wire  [`DIO_ADDR_WIDTH-1:0] size_i,
	input  wire  [7:0]                 index_i,
	input  wire                        downloading_i,
	input  wire                        uploading_i,
	input  wire  [63:0]                name_i,
	input  wire                        check_i,
	input  wire                        exp_dl_i,
	input  wire                        exp_ul_i,
	output int                         errors_o,
	output logic                       idle_o
);

	// reference model state
	dio_pkg::ram_addr_u wr_ptr;
	dio_pkg::ram_addr_u up_ptr;
	dio_pkg::ram_addr_u wa;
	logic [7:0]         cmd;
	logic [7:0]         index;
	logic               dl;
	logic               ul;
	// bytes downloaded since the last start
	logic [`DIO_ADDR_WIDTH-1:0] dl_count;
	// frame reassembly from the bytes seen on sdi and sdo
	logic [7:0]         rx_sr;
	logic [7:0]         tx_sr;
	logic [7:0]         stat;
	logic               in_frame;
	int                 nbit;
	int                 nbyte;
	int                 cyc = 0;
	int                 pend = 0;
	int                 errors = 0;
	logic               chk_pend = 1'b0;
	// expected ram writes in order with due cycle, address and data
	int                         wq_due [$];
	logic [`DIO_ADDR_WIDTH-1:0] wq_addr [$];
	logic [7:0]                 wq_data [$];

	assign errors_o = errors;
	assign idle_o   = (pend == 0);

	// the testbench ram returns an xor pattern of the address
	function automatic logic [7:0] ram_byte(input logic [`DIO_ADDR_WIDTH-1:0] ad);
		ram_byte = ad[7:0] ^ ad[15:8] ^ ad[23:16] ^ 8'h5a;
	endfunction

	task automatic compare_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch %0s %0s: expected %0h actual %0h", name_i, what, exp, act);
			errors++;
		end
	endtask

	task automatic pop_write();
		void'(wq_due.pop_front());
		void'(wq_addr.pop_front());
		void'(wq_data.pop_front());
		pend--;
	endtask

	// run one received byte through the model and check the returned byte
	task automatic take_byte();
		logic [7:0] exp_tx;
		exp_tx = stat;
		if (nbyte == 0) begin
			cmd = rx_sr;
		end else begin
			case (cmd)
				`DIO_CMD_FILE_TX: begin
					// only one transfer direction at a time
					if (rx_sr != 8'h00) begin
						wr_ptr   = `DIO_START_ADDR;
						dl_count = '0;
						dl       = 1'b1;
						ul       = 1'b0;
					end else begin
						dl = 1'b0;
					end
				end
				`DIO_CMD_FILE_TX_DAT: begin
					// write shows up two cycles after the byte strobe
					wq_due.push_back(cyc + 2);
					wq_addr.push_back(wr_ptr.flat);
					wq_data.push_back(rx_sr);
					pend++;
					wr_ptr.flat = wr_ptr.flat + 1;
					dl_count    = dl_count + 1;
				end
				`DIO_CMD_FILE_INDEX: index = rx_sr;
				`DIO_CMD_FILE_RX: begin
					if (rx_sr != 8'h00) begin
						up_ptr = `DIO_START_ADDR;
						ul     = 1'b1;
						dl     = 1'b0;
					end else begin
						ul = 1'b0;
					end
				end
				`DIO_CMD_FILE_RX_DAT: begin
					exp_tx      = ram_byte(up_ptr.flat);
					up_ptr.flat = up_ptr.flat + 1;
				end
				default: ;
			endcase
		end
		compare_val("returned byte", exp_tx, tx_sr);
	endtask

	// ********************
	// serial side sampled on rising sck
	// ********************
	always @(posedge sck) begin
		cyc = cyc + 1;
		if (check_i)
			chk_pend = 1'b1;
		if (ss) begin
			wr_ptr   = `DIO_START_ADDR;
			up_ptr   = `DIO_START_ADDR;
			dl_count = '0;
			dl       = 1'b0;
			ul       = 1'b0;
			index    = 8'h00;
			in_frame = 1'b0;
			nbit     = 0;
			nbyte    = 0;
		end else if (!frame_i) begin
			in_frame = 1'b0;
			nbit     = 0;
			nbyte    = 0;
			compare_val("idle sdo", 0, sdo_i);
		end else begin
			if (!in_frame) begin
				// status returned in this frame is the state before it
				in_frame = 1'b1;
				stat     = {dl, ul, 6'b000000};
			end
			rx_sr = {rx_sr[6:0], sdi_i};
			tx_sr = {tx_sr[6:0], sdo_i};
			nbit++;
			if (nbit == 8) begin
				nbit = 0;
				take_byte();
				nbyte++;
			end
		end
	end

	// ********************
	// ram port and state sampled on falling sck
	// ********************
	always @(negedge sck) begin
		if (ss === 1'b0) begin
			if (wr_i) begin
				if (pend == 0) begin
					$display("error: ram write to %h with no data byte behind it", a_i);
					errors++;
				end else begin
					wa = wq_addr[0];
					compare_val("write cycle", wq_due[0], cyc);
					compare_val("write addr", wa.flat, a_i);
					compare_val("write sel", 4'b0001 << wa.w.lane, sel_i);
					compare_val("write data", {4{wq_data[0]}}, dout_i);
					pop_write();
				end
			end else if (pend != 0 && wq_due[0] <= cyc) begin
				$display("error: ram write to %h was due and never came", wq_addr[0]);
				errors++;
				pop_write();
			end
			if (chk_pend) begin
				chk_pend = 1'b0;
				compare_val("downloading", exp_dl_i, downloading_i);
				compare_val("uploading", exp_ul_i, uploading_i);
				compare_val("size", dl_count, size_i);
				compare_val("index", index, index_i);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/data_io_top.sv
// data_io top level
// byte interface between the io controller and the core, serial receiver,
// file command decoder, ram port and serial transmitter on one clock

`default_nettype none

`include "dio_defs.svh"

module data_io_top (
	input  wire                        sck,
	input  wire                        ss,
	input  wire                        frame_i,
	input  wire                        sdi_i,
	output logic                       sdo_o,
	// external ram
	output logic                       wr_o,
	output logic [`DIO_ADDR_WIDTH-1:0] a_o,
	output logic [3:0]                 sel_o,
	output logic [31:0]                dout_o,
	input  wire  [7:0]                 din_i,
	// transfer state towards the core
	output logic [`DIO_ADDR_WIDTH-1:0] size_o,
	output logic [7:0]                 index_o,
	output logic                       downloading_o,
	output logic                       uploading_o
);

	// receiver outputs
	logic [7:0]         rx_byte;
	logic               rx_strobe;
	logic [4:0]         rx_byte_idx;
	logic [7:0]         rx_cmd;
	logic [2:0]         rx_bit_idx;
	// decoder to ram port
	logic               wr_req;
	dio_pkg::ram_addr_u wr_addr;
	logic [7:0]         wr_data;
	dio_pkg::ram_addr_u rd_addr;

	spi_shift_in u_rx (
		.sck(sck), .ss(ss), .frame_i(frame_i), .sdi_i(sdi_i),
		.byte_o(rx_byte), .byte_strobe_o(rx_strobe), .byte_idx_o(rx_byte_idx),
		.cmd_o(rx_cmd), .bit_idx_o(rx_bit_idx)
	);

	dio_cmd_decoder u_dec (
		.sck(sck), .ss(ss), .byte_i(rx_byte), .byte_strobe_i(rx_strobe),
		.byte_idx_i(rx_byte_idx), .cmd_i(rx_cmd),
		.wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .rd_addr_o(rd_addr),
		.size_o(size_o), .index_o(index_o),
		.downloading_o(downloading_o), .uploading_o(uploading_o)
	);

	ram_port u_ram (
		.sck(sck), .ss(ss), .wr_req_i(wr_req), .wr_addr_i(wr_addr),
		.wr_data_i(wr_data), .rd_addr_i(rd_addr),
		.wr_o(wr_o), .a_o(a_o), .sel_o(sel_o), .dout_o(dout_o)
	);

	spi_shift_out u_tx (
		.sck(sck), .ss(ss), .frame_i(frame_i), .bit_idx_i(rx_bit_idx), .cmd_i(rx_cmd),
		.din_i(din_i), .downloading_i(downloading_o), .uploading_i(uploading_o),
		.sdo_o(sdo_o)
	);

endmodule

`default_nettype wire

//--- verilog/spi_shift_out.sv
// serial transmitter of the data interface
// works on falling sck edges, one slot per received byte
// upload data frames return ram bytes, every other slot the status byte

`default_nettype none

`include "dio_defs.svh"

module spi_shift_out (
	input  wire       sck,
	input  wire       ss,
	input  wire       frame_i,
	input  wire [2:0] bit_idx_i,
	input  wire [7:0] cmd_i,
	input  wire [7:0] din_i,
	input  wire       downloading_i,
	input  wire       uploading_i,
	output logic      sdo_o
);

	logic [7:0] din_r;
	logic [7:0] stat_r;
	logic [7:0] stat_now;
	logic       sdo_r;

	always_comb begin
		stat_now = 8'h00;
		stat_now[`DIO_STAT_DOWNLOAD] = downloading_i;
		stat_now[`DIO_STAT_UPLOAD]   = uploading_i;
	end

	// ram byte for the next slot, fetched before its msb goes out
	always_ff @(negedge sck) begin
		if (bit_idx_i == 3'd7)
			din_r <= din_i;
	end

	always_ff @(negedge sck or posedge ss) begin
		if (ss) begin
			stat_r <= 8'h00;
			sdo_r  <= 1'b0;
		end else begin
			// status follows the flags until a command arrives,
			// then stays frozen for the rest of the frame
			if (cmd_i == 8'h00)
				stat_r <= stat_now;
			if (cmd_i == `DIO_CMD_FILE_RX_DAT)
				sdo_r <= din_r[~bit_idx_i];
			else
				sdo_r <= stat_r[~bit_idx_i];
		end
	end

	// line stays quiet between frames
	assign sdo_o = frame_i & sdo_r;

endmodule

`default_nettype wire

//--- verilog/ram_port.sv
// external ram port
// registers each write request, turns the byte lane of the address into
// the 32 bit bus byte select and shows the upload address while idle

`default_nettype none

`include "dio_defs.svh"

module ram_port (
	input  wire                        sck,
	input  wire                        ss,
	input  wire                        wr_req_i,
	input  wire  dio_pkg::ram_addr_u   wr_addr_i,
	input  wire  [7:0]                 wr_data_i,
	input  wire  dio_pkg::ram_addr_u   rd_addr_i,
	output logic                       wr_o,
	output logic [`DIO_ADDR_WIDTH-1:0] a_o,
	output logic [3:0]                 sel_o,
	output logic [31:0]                dout_o
);

	dio_pkg::ram_addr_u a_r;
	logic [7:0]         data_r;

	assign a_o    = a_r.flat;
	// same byte on every lane, sel_o picks the one that counts
	assign dout_o = {4{data_r}};

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			wr_o  <= 1'b0;
			a_r   <= `DIO_START_ADDR;
			sel_o <= 4'b0000;
		end else begin
			wr_o <= wr_req_i;
			if (wr_req_i) begin
				a_r <= wr_addr_i;
				case (wr_addr_i.w.lane)
					2'd0:    sel_o <= 4'b0001;
					2'd1:    sel_o <= 4'b0010;
					2'd2:    sel_o <= 4'b0100;
					default: sel_o <= 4'b1000;
				endcase
			end else begin
				// no write, ram reads the upload address
				a_r   <= rd_addr_i;
				sel_o <= 4'b0000;
			end
		end
	end

	always_ff @(posedge sck) begin
		if (wr_req_i)
			data_r <= wr_data_i;
	end

	// the select must match the low bits of the address it goes with
	a_sel_lane: assert property (
		@(posedge sck) disable iff (ss) wr_o |-> (sel_o == (4'b0001 << a_o[1:0])));

endmodule

`default_nettype wire

//--- verilog/dio_cmd_decoder.sv
// file transfer command decoder
// acts on every parameter byte of a frame, one cycle after its strobe
// keeps download and upload pointers, menu index and the transfer flags
// and requests one ram write per download data byte

`default_nettype none

`include "dio_defs.svh"

module dio_cmd_decoder (
	input  wire                        sck,
	input  wire                        ss,
	input  wire  [7:0]                 byte_i,
	input  wire                        byte_strobe_i,
	input  wire  [4:0]                 byte_idx_i,
	input  wire  [7:0]                 cmd_i,
	output logic                       wr_req_o,
	output dio_pkg::ram_addr_u         wr_addr_o,
	output logic [7:0]                 wr_data_o,
	output dio_pkg::ram_addr_u         rd_addr_o,
	output logic [`DIO_ADDR_WIDTH-1:0] size_o,
	output logic [7:0]                 index_o,
	output logic                       downloading_o,
	output logic                       uploading_o
);

	// next download address
	dio_pkg::ram_addr_u wr_ptr;
	// address of the upload byte most recently handed out
	dio_pkg::ram_addr_u rd_ptr;
	logic               param_strobe;
	logic               rx_dat_frame;

	// the command byte itself carries nothing to execute
	assign param_strobe = byte_strobe_i & (byte_idx_i != 5'd0);
	assign rx_dat_frame = (cmd_i == `DIO_CMD_FILE_RX_DAT);

	// bytes downloaded since the last start
	assign size_o = wr_ptr.flat - `DIO_START_ADDR;

	// the transmitter loads the next slot before the current byte is
	// strobed, so inside an upload data frame look one address ahead
	assign rd_addr_o.flat = rd_ptr.flat + `DIO_ADDR_WIDTH'(rx_dat_frame);

	// ********************
	// command execution
	// ********************

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			wr_req_o      <= 1'b0;
			wr_addr_o     <= `DIO_START_ADDR;
			wr_ptr        <= `DIO_START_ADDR;
			rd_ptr        <= `DIO_START_ADDR;
			index_o       <= 8'h00;
			downloading_o <= 1'b0;
			uploading_o   <= 1'b0;
		end else begin
			wr_req_o <= 1'b0;
			if (param_strobe) begin
				case (cmd_i)
					// start or stop download
					`DIO_CMD_FILE_TX: begin
						if (byte_i != 8'h00) begin
							wr_ptr        <= `DIO_START_ADDR;
							downloading_o <= 1'b1;
							uploading_o   <= 1'b0;
						end else begin
							downloading_o <= 1'b0;
						end
					end
					// one data byte, write and step the address
					`DIO_CMD_FILE_TX_DAT: begin
						wr_req_o       <= 1'b1;
						wr_addr_o      <= wr_ptr;
						wr_ptr.flat    <= wr_ptr.flat + `DIO_ADDR_WIDTH'(1);
					end
					`DIO_CMD_FILE_INDEX: index_o <= byte_i;
					// start or stop upload
					`DIO_CMD_FILE_RX: begin
						if (byte_i != 8'h00) begin
							rd_ptr        <= `DIO_START_ADDR;
							uploading_o   <= 1'b1;
							downloading_o <= 1'b0;
						end else begin
							uploading_o <= 1'b0;
						end
					end
					// controller consumed one upload byte
					`DIO_CMD_FILE_RX_DAT: rd_ptr.flat <= rd_ptr.flat + `DIO_ADDR_WIDTH'(1);
					default: ;
				endcase
			end
		end
	end

	// write data is payload only, follows the write request
	always_ff @(posedge sck) begin
		if (param_strobe && cmd_i == `DIO_CMD_FILE_TX_DAT)
			wr_data_o <= byte_i;
	end

	// the core never sees both transfer directions at once
	a_one_direction: assert property (
		@(posedge sck) disable iff (ss) !(downloading_o && uploading_o));

endmodule

`default_nettype wire

//--- verilog/spi_shift_in.sv
// serial receiver of the data interface
// assembles msb first bytes from sdi, counts bits and bytes inside a frame
// and keeps the first byte of the frame as the command

`default_nettype none

module spi_shift_in (
	input  wire        sck,
	input  wire        ss,
	input  wire        frame_i,
	input  wire        sdi_i,
	output logic [7:0] byte_o,
	output logic       byte_strobe_o,
	output logic [4:0] byte_idx_o,
	output logic [7:0] cmd_o,
	output logic [2:0] bit_idx_o
);

	// seven bits collected so far, the eighth comes straight from sdi
	logic [6:0] sbuf;
	// bytes seen in this frame, sticks at 31
	logic [4:0] byte_cnt;
	logic       byte_done;
	logic [7:0] new_byte;

	assign byte_done = frame_i & (&bit_idx_o);
	assign new_byte  = {sbuf, sdi_i};

	// data path, shift register and received byte
	always_ff @(posedge sck) begin
		if (frame_i) begin
			sbuf <= {sbuf[5:0], sdi_i};
		end
		if (byte_done) begin
			byte_o <= new_byte;
		end
	end

	// counters, strobe and command latch
	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			bit_idx_o     <= 3'd0;
			byte_cnt      <= 5'd0;
			byte_idx_o    <= 5'd0;
			byte_strobe_o <= 1'b0;
			cmd_o         <= 8'h00;
		end else begin
			byte_strobe_o <= byte_done;
			if (!frame_i) begin
				// frame over, start clean for the next one
				bit_idx_o <= 3'd0;
				byte_cnt  <= 5'd0;
				cmd_o     <= 8'h00;
			end else begin
				bit_idx_o <= bit_idx_o + 3'd1;
				if (byte_done) begin
					byte_idx_o <= byte_cnt;
					if (byte_cnt == 5'd0)
						cmd_o <= new_byte;
					if (~&byte_cnt)
						byte_cnt <= byte_cnt + 5'd1;
				end
			end
		end
	end

	// bytes are at least 8 clocks apart, a strobe is one cycle only
	a_strobe_single: assert property (
		@(posedge sck) disable iff (ss) byte_strobe_o |=> !byte_strobe_o);

endmodule

`default_nettype wire

//--- verilog/dio_pkg.sv
// data_io package
// types shared between the command decoder, the ram port and the top

`default_nettype none

package dio_pkg;

	`include "dio_defs.svh"

	// one ram address word, seen either as a flat byte address
	// (counted up by the decoder) or split into word and byte lane
	// (decoded into the 4 byte selects of the 32 bit ram bus)
	typedef union packed {
		logic [`DIO_ADDR_WIDTH-1:0] flat;
		struct packed {
			logic [`DIO_ADDR_WIDTH-3:0] word;
			logic [1:0]                 lane;
		} w;
	} ram_addr_u;

endpackage

`default_nettype wire

//--- include/dio_defs.svh
// data_io shared definitions
// ram address geometry and the file transfer command set
// spoken by the io controller on the serial link

`ifndef DIO_DEFS_SVH
`define DIO_DEFS_SVH

// ********************
// ram address
// ********************

// byte address width of the external ram port
`define DIO_ADDR_WIDTH 24

// first byte of every up- or download
`define DIO_START_ADDR 24'h00_0000

// ********************
// file transfer commands
// ********************

`define DIO_CMD_FILE_TX     8'h53
`define DIO_CMD_FILE_TX_DAT 8'h54
`define DIO_CMD_FILE_INDEX  8'h55
`define DIO_CMD_FILE_RX     8'h57
`define DIO_CMD_FILE_RX_DAT 8'h58

// bit positions inside the status byte returned to the controller
`define DIO_STAT_DOWNLOAD 7
`define DIO_STAT_UPLOAD   6

`endif
